/* include/decode2_consts.svh */
`ifndef DECODE2_CONSTS_SVH
`define DECODE2_CONSTS_SVH

// Instruction window, byte 0 is the first byte of the instruction
`define DEC_WIN_BYTES 13
// Number of 4-byte word positions in the window
`define DEC_WIN_WORDS 10

`define DEC_EIP_W 32
// Instruction length in bytes
`define DEC_LEN_W 4

// Segment override prefix bytes
`define DEC_PFX_CS 8'h2E
`define DEC_PFX_DS 8'h3E
`define DEC_PFX_ES 8'h26
`define DEC_PFX_SS 8'h36
`define DEC_PFX_FS 8'h64
`define DEC_PFX_GS 8'h65

`endif

/* design/decode2_pkg.sv */
`default_nettype none

package decode2_pkg;

	// Field size code, 00 none, 01 byte, 10 word, 11 dword
	typedef enum logic [1:0] {
		NONE = 2'b00,
		B8   = 2'b01,
		B16  = 2'b10,
		B32  = 2'b11
	} size_code_e;

	// Segment register number
	typedef enum logic [2:0] {
		CS = 3'd0,
		DS = 3'd1,
		ES = 3'd2,
		SS = 3'd3,
		FS = 3'd4,
		GS = 3'd5
	} seg_code_e;

	// 16:16 far pointer as laid out in the immediate word
	typedef struct packed {
		logic [15:0] offset;
		logic [15:0] selector;
	} far_ptr_s;

	// Immediate word, plain or as a far pointer
	typedef union packed {
		logic [31:0] raw;
		far_ptr_s    far;
	} imm_word_u;

endpackage

`default_nettype wire

/* design/dec_window_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

interface dec_window_if (
	input wire logic CLK,
	input wire logic i_rst_n
);

	logic has_imm8;
	logic has_imm16;
	logic has_imm32;
	logic has_disp8;
	logic has_disp32;
	logic has_modrm;
	logic has_sib;
	logic has_seg_prefix;
	logic opsize_prefix;
	logic far_ptr;

	logic [`DEC_LEN_W-1:0] length;
	logic [7:0]            seg_prefix_byte;
	logic [7:0]            modrm_byte;
	logic [7:0]            sib_byte;
	// Byte 0 sits in the top byte of the packed window
	logic [0:`DEC_WIN_BYTES-1][7:0] window;
	logic [`DEC_EIP_W-1:0] eip;

	modport capture (
		output has_imm8, has_imm16, has_imm32, has_disp8, has_disp32,
		output has_modrm, has_sib, has_seg_prefix, opsize_prefix, far_ptr,
		output length, seg_prefix_byte, modrm_byte, sib_byte, window, eip
	);

	// Clock and reset only feed the checks in operand_extract
	modport operand (
		input CLK, i_rst_n,
		input has_imm8, has_imm16, has_imm32, has_disp8, has_disp32,
		input length, window
	);

	modport addr (
		input has_modrm, has_sib, has_seg_prefix,
		input seg_prefix_byte, modrm_byte, sib_byte
	);

	modport assemble (
		input length, eip, opsize_prefix, far_ptr
	);

endinterface

`default_nettype wire

/* design/decode2_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module decode2_capture (
	input  wire logic                         CLK,
	input  wire logic                         i_rst_n,
	input  wire logic                         i_valid,
	output logic                              o_ready,
	input  wire logic                         i_has_imm8,
	input  wire logic                         i_has_imm16,
	input  wire logic                         i_has_imm32,
	input  wire logic                         i_has_disp8,
	input  wire logic                         i_has_disp32,
	input  wire logic                         i_has_modrm,
	input  wire logic                         i_has_sib,
	input  wire logic                         i_has_seg_prefix,
	input  wire logic                         i_opsize_prefix,
	input  wire logic                         i_far_ptr,
	input  wire logic [`DEC_LEN_W-1:0]        i_length,
	input  wire logic [7:0]                   i_seg_prefix_byte,
	input  wire logic [7:0]                   i_modrm_byte,
	input  wire logic [7:0]                   i_sib_byte,
	input  wire logic [8*`DEC_WIN_BYTES-1:0]  i_window,
	input  wire logic [`DEC_EIP_W-1:0]        i_eip,
	dec_window_if.capture                     win,
	output logic                              o_cap_valid,
	input  wire logic                         i_asm_ready
);

	logic take;

	// Room when empty or when the held entry leaves this cycle
	assign o_ready = !o_cap_valid || i_asm_ready;
	assign take    = i_valid && o_ready;

	always_ff @(posedge CLK) begin
		if (!i_rst_n) begin
			o_cap_valid        <= 1'b0;
			win.has_imm8       <= 1'b0;
			win.has_imm16      <= 1'b0;
			win.has_imm32      <= 1'b0;
			win.has_disp8      <= 1'b0;
			win.has_disp32     <= 1'b0;
			win.has_modrm      <= 1'b0;
			win.has_sib        <= 1'b0;
			win.has_seg_prefix <= 1'b0;
			win.opsize_prefix  <= 1'b0;
			win.far_ptr        <= 1'b0;
			win.length         <= '0;
		end else begin
			if (o_ready)
				o_cap_valid <= i_valid;
			if (take) begin
				win.has_imm8       <= i_has_imm8;
				win.has_imm16      <= i_has_imm16;
				win.has_imm32      <= i_has_imm32;
				win.has_disp8      <= i_has_disp8;
				win.has_disp32     <= i_has_disp32;
				win.has_modrm      <= i_has_modrm;
				win.has_sib        <= i_has_sib;
				win.has_seg_prefix <= i_has_seg_prefix;
				win.opsize_prefix  <= i_opsize_prefix;
				win.far_ptr        <= i_far_ptr;
				win.length         <= i_length;
			end
		end
	end

	// Instruction bytes and EIP
	always_ff @(posedge CLK) begin
		if (take) begin
			win.seg_prefix_byte <= i_seg_prefix_byte;
			win.modrm_byte      <= i_modrm_byte;
			win.sib_byte        <= i_sib_byte;
			win.window          <= i_window;
			win.eip             <= i_eip;
		end
	end

	// Stalled instruction must stay on the inputs until taken
	property p_hold_stable;
		@(posedge CLK) disable iff (!i_rst_n)
		i_valid && !o_ready |=>
			i_valid && $stable(i_window) && $stable(i_eip) && $stable(i_length);
	endproperty
	a_hold_stable: assert property (p_hold_stable)
		else $error("upstream instruction changed while stalled");

endmodule

`default_nettype wire

/* design/operand_extract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module operand_extract (
	dec_window_if.operand           win,
	output decode2_pkg::imm_word_u  o_imm_word,
	output logic [31:0]             o_disp_word,
	output decode2_pkg::size_code_e o_imm_size,
	output decode2_pkg::size_code_e o_disp_size
);

	logic [`DEC_LEN_W-1:0]             imm_cnt;
	logic [`DEC_LEN_W-1:0]             disp_cnt;
	logic [`DEC_LEN_W-1:0]             imm_pos;
	logic [`DEC_LEN_W-1:0]             disp_pos;
	logic [`DEC_WIN_WORDS-1:0][31:0]   words;

	// Byte counts of the trailing fields
	assign imm_cnt  = win.has_imm32 ? 4'd4 :
	                  win.has_imm16 ? 4'd2 :
	                  win.has_imm8  ? 4'd1 : 4'd0;
	assign disp_cnt = win.has_disp32 ? 4'd4 :
	                  win.has_disp8  ? 4'd1 : 4'd0;

	// Immediate ends the instruction, displacement sits right before it
	assign imm_pos  = win.length - imm_cnt;
	assign disp_pos = imm_pos - disp_cnt;

	// All 4-byte words, first byte in the top byte
	always_comb begin
		for (int p = 0; p < `DEC_WIN_WORDS; p++)
			words[p] = win.window[p +: 4];
	end

	assign o_imm_word.raw = words[imm_pos];
	assign o_disp_word    = words[disp_pos];

	assign o_imm_size  = win.has_imm32 ? decode2_pkg::B32 :
	                     win.has_imm16 ? decode2_pkg::B16 :
	                     win.has_imm8  ? decode2_pkg::B8  : decode2_pkg::NONE;
	assign o_disp_size = win.has_disp32 ? decode2_pkg::B32 :
	                     win.has_disp8  ? decode2_pkg::B8  : decode2_pkg::NONE;

	// Flags come from the predecoder and must be consistent
	a_one_imm: assert property (@(posedge win.CLK) disable iff (!win.i_rst_n)
		$onehot0({win.has_imm8, win.has_imm16, win.has_imm32}))
		else $error("more than one immediate size flag");
	a_one_disp: assert property (@(posedge win.CLK) disable iff (!win.i_rst_n)
		$onehot0({win.has_disp8, win.has_disp32}))
		else $error("more than one displacement size flag");
	a_pos_range: assert property (@(posedge win.CLK) disable iff (!win.i_rst_n)
		imm_pos <= `DEC_WIN_WORDS - 1 && disp_pos <= `DEC_WIN_WORDS - 1)
		else $error("field position outside the window");

endmodule

`default_nettype wire

/* design/addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module addr_decode (
	dec_window_if.addr             win,
	output logic                   o_sib,
	output logic [1:0]             o_scale,
	output logic [2:0]             o_index,
	output logic [2:0]             o_base,
	output logic                   o_abs_addr,
	output decode2_pkg::seg_code_e o_seg
);

	logic                   mod_00;
	logic                   rm_101;
	decode2_pkg::seg_code_e pfx_seg;

	// SIB fields go out raw
	assign o_sib   = win.has_sib;
	assign o_scale = win.sib_byte[7:6];
	assign o_index = win.sib_byte[5:3];
	assign o_base  = win.sib_byte[2:0];

	// mod 00 with rm 101 means disp32 with no base register
	assign mod_00     = win.modrm_byte[7:6] == 2'b00;
	assign rm_101     = win.modrm_byte[2:0] == 3'b101;
	assign o_abs_addr = win.has_modrm && mod_00 && rm_101;

	always_comb begin
		case (win.seg_prefix_byte)
			`DEC_PFX_CS: pfx_seg = decode2_pkg::CS;
			`DEC_PFX_DS: pfx_seg = decode2_pkg::DS;
			`DEC_PFX_ES: pfx_seg = decode2_pkg::ES;
			`DEC_PFX_SS: pfx_seg = decode2_pkg::SS;
			`DEC_PFX_FS: pfx_seg = decode2_pkg::FS;
			`DEC_PFX_GS: pfx_seg = decode2_pkg::GS;
			// Not a segment prefix
			default:     pfx_seg = decode2_pkg::DS;
		endcase
	end

	// DS unless overridden
	assign o_seg = win.has_seg_prefix ? pfx_seg : decode2_pkg::DS;

endmodule

`default_nettype wire

/* design/decode2_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module decode2_assemble (
	input  wire logic                     CLK,
	input  wire logic                     i_rst_n,
	dec_window_if.assemble                win,
	input  wire logic                     i_cap_valid,
	output logic                          o_asm_ready,
	input  var  decode2_pkg::imm_word_u   i_imm_word,
	input  wire logic [31:0]              i_disp_word,
	input  var  decode2_pkg::size_code_e  i_imm_size,
	input  var  decode2_pkg::size_code_e  i_disp_size,
	input  wire logic                     i_sib,
	input  wire logic [1:0]               i_scale,
	input  wire logic [2:0]               i_index,
	input  wire logic [2:0]               i_base,
	input  wire logic                     i_abs_addr,
	input  var  decode2_pkg::seg_code_e   i_seg,
	output logic                          o_valid,
	input  wire logic                     i_ready,
	output logic [31:0]                   o_imm,
	output logic [31:0]                   o_disp,
	output decode2_pkg::size_code_e       o_imm_size,
	output decode2_pkg::size_code_e       o_disp_size,
	output logic                          o_sib,
	output logic [1:0]                    o_scale,
	output logic [2:0]                    o_index,
	output logic [2:0]                    o_base,
	output logic                          o_abs_addr,
	output decode2_pkg::seg_code_e        o_seg,
	output logic [`DEC_EIP_W-1:0]         o_eip,
	output logic [`DEC_EIP_W-1:0]         o_next_eip
);

	logic                  take;
	logic                  far16;
	logic [`DEC_EIP_W-1:0] next_eip;

	assign o_asm_ready = !o_valid || i_ready;
	assign take        = i_cap_valid && o_asm_ready;

	// 16:16 far pointer, offset in the upper half and selector below it
	assign far16    = win.far_ptr && win.opsize_prefix && i_imm_size == decode2_pkg::B32;
	assign next_eip = win.eip + {{(`DEC_EIP_W-`DEC_LEN_W){1'b0}}, win.length};

	always_ff @(posedge CLK) begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else if (o_asm_ready)
			o_valid <= i_cap_valid;
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			if (far16) begin
				o_imm       <= {16'h0000, i_imm_word.far.offset};
				o_disp      <= {16'h0000, i_imm_word.far.selector};
				o_imm_size  <= decode2_pkg::B16;
				o_disp_size <= decode2_pkg::B16;
			end else begin
				o_imm       <= i_imm_word.raw;
				o_disp      <= i_disp_word;
				o_imm_size  <= i_imm_size;
				o_disp_size <= i_disp_size;
			end
			o_sib      <= i_sib;
			o_scale    <= i_scale;
			o_index    <= i_index;
			o_base     <= i_base;
			o_abs_addr <= i_abs_addr;
			o_seg      <= i_seg;
			o_eip      <= win.eip;
			o_next_eip <= next_eip;
		end
	end

	// Far pointer opcode always carries a full immediate
	a_far_imm32: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_cap_valid && win.far_ptr && win.opsize_prefix |-> i_imm_size == decode2_pkg::B32)
		else $error("far pointer without a 32-bit immediate");

endmodule

`default_nettype wire

/* design/decode2_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module decode2_top (
	input  wire logic                        CLK,
	input  wire logic                        i_rst_n,
	input  wire logic                        i_valid,
	output logic                             o_ready,
	input  wire logic                        i_has_imm8,
	input  wire logic                        i_has_imm16,
	input  wire logic                        i_has_imm32,
	input  wire logic                        i_has_disp8,
	input  wire logic                        i_has_disp32,
	input  wire logic                        i_has_modrm,
	input  wire logic                        i_has_sib,
	input  wire logic                        i_has_seg_prefix,
	input  wire logic                        i_opsize_prefix,
	input  wire logic                        i_far_ptr,
	input  wire logic [`DEC_LEN_W-1:0]       i_length,
	input  wire logic [7:0]                  i_seg_prefix_byte,
	input  wire logic [7:0]                  i_modrm_byte,
	input  wire logic [7:0]                  i_sib_byte,
	// Byte 0 of the instruction in bits 103:96
	input  wire logic [8*`DEC_WIN_BYTES-1:0] i_window,
	input  wire logic [`DEC_EIP_W-1:0]       i_eip,
	output logic                             o_valid,
	input  wire logic                        i_ready,
	output logic [31:0]                      o_imm,
	output logic [31:0]                      o_disp,
	output decode2_pkg::size_code_e          o_imm_size,
	output decode2_pkg::size_code_e          o_disp_size,
	output logic                             o_sib,
	output logic [1:0]                       o_scale,
	output logic [2:0]                       o_index,
	output logic [2:0]                       o_base,
	output logic                             o_abs_addr,
	output decode2_pkg::seg_code_e           o_seg,
	output logic [`DEC_EIP_W-1:0]            o_eip,
	output logic [`DEC_EIP_W-1:0]            o_next_eip
);

	logic                    cap_valid;
	logic                    asm_ready;
	decode2_pkg::imm_word_u  imm_word;
	logic [31:0]             disp_word;
	decode2_pkg::size_code_e imm_size;
	decode2_pkg::size_code_e disp_size;
	logic                    sib;
	logic [1:0]              scale;
	logic [2:0]              index;
	logic [2:0]              base;
	logic                    abs_addr;
	decode2_pkg::seg_code_e  seg;

	dec_window_if u_win (.CLK(CLK), .i_rst_n(i_rst_n));

	decode2_capture u_capture (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_valid(i_valid), .o_ready(o_ready),
		.i_has_imm8(i_has_imm8), .i_has_imm16(i_has_imm16), .i_has_imm32(i_has_imm32),
		.i_has_disp8(i_has_disp8), .i_has_disp32(i_has_disp32),
		.i_has_modrm(i_has_modrm), .i_has_sib(i_has_sib),
		.i_has_seg_prefix(i_has_seg_prefix), .i_opsize_prefix(i_opsize_prefix),
		.i_far_ptr(i_far_ptr), .i_length(i_length),
		.i_seg_prefix_byte(i_seg_prefix_byte), .i_modrm_byte(i_modrm_byte),
		.i_sib_byte(i_sib_byte), .i_window(i_window), .i_eip(i_eip),
		.win(u_win.capture), .o_cap_valid(cap_valid), .i_asm_ready(asm_ready)
	);

	operand_extract u_operand (
		.win(u_win.operand), .o_imm_word(imm_word), .o_disp_word(disp_word),
		.o_imm_size(imm_size), .o_disp_size(disp_size)
	);

	addr_decode u_addr (
		.win(u_win.addr), .o_sib(sib), .o_scale(scale), .o_index(index),
		.o_base(base), .o_abs_addr(abs_addr), .o_seg(seg)
	);

	decode2_assemble u_assemble (
		.CLK(CLK), .i_rst_n(i_rst_n), .win(u_win.assemble),
		.i_cap_valid(cap_valid), .o_asm_ready(asm_ready),
		.i_imm_word(imm_word), .i_disp_word(disp_word),
		.i_imm_size(imm_size), .i_disp_size(disp_size),
		.i_sib(sib), .i_scale(scale), .i_index(index), .i_base(base),
		.i_abs_addr(abs_addr), .i_seg(seg),
		.o_valid(o_valid), .i_ready(i_ready), .o_imm(o_imm), .o_disp(o_disp),
		.o_imm_size(o_imm_size), .o_disp_size(o_disp_size),
		.o_sib(o_sib), .o_scale(o_scale), .o_index(o_index), .o_base(o_base),
		.o_abs_addr(o_abs_addr), .o_seg(o_seg), .o_eip(o_eip), .o_next_eip(o_next_eip)
	);

endmodule

`default_nettype wire

/* verif/tb_decode2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode2_consts.svh"

module tb_decode2;

	localparam int ITEMS          = 200;
	// 4 tests, 200 items, up to 4 cycles each, plus reset and drain margin
	localparam int TIMEOUT_CYCLES = 4 * ITEMS * 4 + 800;

	typedef struct packed {
		logic [31:0] imm;
		logic [31:0] disp;
		logic [1:0]  imm_size;
		logic [1:0]  disp_size;
		logic        sib;
		logic [1:0]  scale;
		logic [2:0]  index;
		logic [2:0]  base;
		logic        abs_addr;
		logic [2:0]  seg;
		logic [31:0] eip;
		logic [31:0] next_eip;
	} expect_t;

	logic                          CLK;
	logic                          i_rst_n;
	logic                          i_valid;
	logic                          o_ready;
	logic                          i_has_imm8;
	logic                          i_has_imm16;
	logic                          i_has_imm32;
	logic                          i_has_disp8;
	logic                          i_has_disp32;
	logic                          i_has_modrm;
	logic                          i_has_sib;
	logic                          i_has_seg_prefix;
	logic                          i_opsize_prefix;
	logic                          i_far_ptr;
	logic [`DEC_LEN_W-1:0]         i_length;
	logic [7:0]                    i_seg_prefix_byte;
	logic [7:0]                    i_modrm_byte;
	logic [7:0]                    i_sib_byte;
	logic [8*`DEC_WIN_BYTES-1:0]   i_window;
	logic [`DEC_EIP_W-1:0]         i_eip;
	logic                          o_valid;
	logic                          i_ready;
	logic [31:0]                   o_imm;
	logic [31:0]                   o_disp;
	decode2_pkg::size_code_e       o_imm_size;
	decode2_pkg::size_code_e       o_disp_size;
	logic                          o_sib;
	logic [1:0]                    o_scale;
	logic [2:0]                    o_index;
	logic [2:0]                    o_base;
	logic                          o_abs_addr;
	decode2_pkg::seg_code_e        o_seg;
	logic [`DEC_EIP_W-1:0]         o_eip;
	logic [`DEC_EIP_W-1:0]         o_next_eip;

	logic [31:0] lfsr_state;
	expect_t     exp_q [$];
	expect_t     cur_exp;
	string       cur_test;
	int          errors;
	int          checks;
	int          tests;
	int          cycles;

	decode2_top u_dut (
		.CLK(CLK), .i_rst_n(i_rst_n), .i_valid(i_valid), .o_ready(o_ready),
		.i_has_imm8(i_has_imm8), .i_has_imm16(i_has_imm16), .i_has_imm32(i_has_imm32),
		.i_has_disp8(i_has_disp8), .i_has_disp32(i_has_disp32),
		.i_has_modrm(i_has_modrm), .i_has_sib(i_has_sib),
		.i_has_seg_prefix(i_has_seg_prefix), .i_opsize_prefix(i_opsize_prefix),
		.i_far_ptr(i_far_ptr), .i_length(i_length),
		.i_seg_prefix_byte(i_seg_prefix_byte), .i_modrm_byte(i_modrm_byte),
		.i_sib_byte(i_sib_byte), .i_window(i_window), .i_eip(i_eip),
		.o_valid(o_valid), .i_ready(i_ready), .o_imm(o_imm), .o_disp(o_disp),
		.o_imm_size(o_imm_size), .o_disp_size(o_disp_size),
		.o_sib(o_sib), .o_scale(o_scale), .o_index(o_index), .o_base(o_base),
		.o_abs_addr(o_abs_addr), .o_seg(o_seg), .o_eip(o_eip), .o_next_eip(o_next_eip)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Right-shift Galois form, taps 32 31 29 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		return 1'(rand_bits(1));
	endfunction

	// Byte p is the most significant byte of the word at position p
	function automatic logic [31:0] word_at(input logic [8*`DEC_WIN_BYTES-1:0] w, input int p);
		return w[8*`DEC_WIN_BYTES-1 - 8*p -: 32];
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic compare_outputs(input expect_t e);
		check_value("imm", e.imm, o_imm);
		check_value("disp", e.disp, o_disp);
		check_value("imm_size", 32'(e.imm_size), 32'(o_imm_size));
		check_value("disp_size", 32'(e.disp_size), 32'(o_disp_size));
		check_value("sib", 32'(e.sib), 32'(o_sib));
		check_value("scale", 32'(e.scale), 32'(o_scale));
		check_value("index", 32'(e.index), 32'(o_index));
		check_value("base", 32'(e.base), 32'(o_base));
		check_value("abs_addr", 32'(e.abs_addr), 32'(o_abs_addr));
		check_value("seg", 32'(e.seg), 32'(o_seg));
		check_value("eip", e.eip, o_eip);
		check_value("next_eip", e.next_eip, o_next_eip);
	endtask

	// New random instruction on the inputs, expected result into cur_exp
	task automatic drive_item(input int mode);
		logic [8*`DEC_WIN_BYTES-1:0] win_bits;
		logic [1:0]                  isel;
		logic [1:0]                  dsel;
		logic [2:0]                  psel;
		logic                        far16;
		logic                        h8;
		logic                        h16;
		logic                        h32;
		logic                        d8;
		logic                        d32;
		logic                        hmod;
		logic                        hsib;
		logic                        hseg;
		logic                        opsz;
		logic [7:0]                  modrm;
		logic [7:0]                  sib;
		logic [7:0]                  pfx;
		logic [31:0]                 eip;
		logic [31:0]                 iword;
		int                          icnt;
		int                          dcnt;
		int                          len;
		int                          ipos;
		int                          dpos;
		expect_t                     e;
		win_bits = '0;
		for (int i = 0; i < `DEC_WIN_BYTES; i++)
			win_bits = {win_bits[8*`DEC_WIN_BYTES-9:0], 8'(rand_bits(8))};
		eip   = rand_bits(32);
		far16 = (mode == 2) && rand_bit();
		isel  = far16 ? 2'd3 : 2'(rand_bits(2));
		dsel  = 2'(rand_bits(2));
		h8    = isel == 2'd1;
		h16   = isel == 2'd2;
		h32   = isel == 2'd3;
		d8    = dsel == 2'd1;
		d32   = dsel[1];
		icnt  = h32 ? 4 : h16 ? 2 : h8 ? 1 : 0;
		dcnt  = d32 ? 4 : d8 ? 1 : 0;
		// Keeps both positions within 0 to 9
		len   = icnt + dcnt + int'(rand_bits(4)) % (10 - dcnt);
		ipos  = len - icnt;
		dpos  = ipos - dcnt;
		opsz  = far16 | rand_bit();
		hmod  = rand_bit();
		modrm = 8'(rand_bits(8));
		if (mode == 1 && rand_bit()) begin
			hmod  = 1'b1;
			modrm = {2'b00, modrm[5:3], 3'b101};
		end
		hsib = rand_bit();
		sib  = 8'(rand_bits(8));
		psel = 3'(rand_bits(3));
		case (psel)
			3'd0:    pfx = `DEC_PFX_CS;
			3'd1:    pfx = `DEC_PFX_DS;
			3'd2:    pfx = `DEC_PFX_ES;
			3'd3:    pfx = `DEC_PFX_SS;
			3'd4:    pfx = `DEC_PFX_FS;
			3'd5:    pfx = `DEC_PFX_GS;
			default: pfx = 8'(rand_bits(8));
		endcase
		hseg = psel != 3'd7;

		// Reference model
		iword = word_at(win_bits, ipos);
		if (far16) begin
			e.imm       = {16'h0000, iword[31:16]};
			e.disp      = {16'h0000, iword[15:0]};
			e.imm_size  = decode2_pkg::B16;
			e.disp_size = decode2_pkg::B16;
		end else begin
			e.imm       = iword;
			e.disp      = word_at(win_bits, dpos);
			e.imm_size  = h32 ? decode2_pkg::B32 : h16 ? decode2_pkg::B16 :
			              h8 ? decode2_pkg::B8 : decode2_pkg::NONE;
			e.disp_size = d32 ? decode2_pkg::B32 : d8 ? decode2_pkg::B8 : decode2_pkg::NONE;
		end
		e.sib      = hsib;
		e.scale    = sib[7:6];
		e.index    = sib[5:3];
		e.base     = sib[2:0];
		e.abs_addr = hmod && modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101;
		if (!hseg)
			e.seg = decode2_pkg::DS;
		else begin
			case (pfx)
				`DEC_PFX_CS: e.seg = decode2_pkg::CS;
				`DEC_PFX_DS: e.seg = decode2_pkg::DS;
				`DEC_PFX_ES: e.seg = decode2_pkg::ES;
				`DEC_PFX_SS: e.seg = decode2_pkg::SS;
				`DEC_PFX_FS: e.seg = decode2_pkg::FS;
				`DEC_PFX_GS: e.seg = decode2_pkg::GS;
				default:     e.seg = decode2_pkg::DS;
			endcase
		end
		e.eip      = eip;
		e.next_eip = eip + 32'(len);
		cur_exp    = e;

		i_valid           <= 1'b1;
		i_has_imm8        <= h8;
		i_has_imm16       <= h16;
		i_has_imm32       <= h32;
		i_has_disp8       <= d8;
		i_has_disp32      <= d32;
		i_has_modrm       <= hmod;
		i_has_sib         <= hsib;
		i_has_seg_prefix  <= hseg;
		i_opsize_prefix   <= opsz;
		i_far_ptr         <= far16;
		i_length          <= len[3:0];
		i_seg_prefix_byte <= pfx;
		i_modrm_byte      <= modrm;
		i_sib_byte        <= sib;
		i_window          <= win_bits;
		i_eip             <= eip;
	endtask

	// Mode 0 operands, 1 addressing, 2 far pointer, 3 back-pressure
	task automatic run_test(input string name, input int mode);
		int      sent;
		int      recv;
		int      err0;
		expect_t e;
		sent     = 0;
		recv     = 0;
		err0     = errors;
		cur_test = name;
		while (sent < ITEMS || exp_q.size() > 0) begin
			@(posedge CLK);
			// Pre-edge values decide both transfers of this edge
			if (o_valid && i_ready) begin
				recv++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: output appeared with no instruction outstanding", name);
				end else begin
					e = exp_q.pop_front();
					compare_outputs(e);
				end
			end
			if (i_valid && o_ready) begin
				exp_q.push_back(cur_exp);
				sent++;
			end
			if (!i_valid || o_ready) begin
				if (sent < ITEMS && (mode != 3 || rand_bit()))
					drive_item(mode);
				else
					i_valid <= 1'b0;
			end
			i_ready <= (mode == 3) ? rand_bit() : 1'b1;
		end
		check_value("output count", 32'(sent), 32'(recv));
		tests++;
		$display("Test %s: %0d in, %0d out, %0d mismatches", name, sent, recv, errors - err0);
	endtask

	initial begin
		lfsr_state        = 32'd76507;
		errors            = 0;
		checks            = 0;
		tests             = 0;
		i_rst_n           = 1'b0;
		i_valid           = 1'b0;
		i_ready           = 1'b1;
		i_has_imm8        = 1'b0;
		i_has_imm16       = 1'b0;
		i_has_imm32       = 1'b0;
		i_has_disp8       = 1'b0;
		i_has_disp32      = 1'b0;
		i_has_modrm       = 1'b0;
		i_has_sib         = 1'b0;
		i_has_seg_prefix  = 1'b0;
		i_opsize_prefix   = 1'b0;
		i_far_ptr         = 1'b0;
		i_length          = '0;
		i_seg_prefix_byte = 8'h00;
		i_modrm_byte      = 8'h00;
		i_sib_byte        = 8'h00;
		i_window          = '0;
		i_eip             = '0;
		repeat (3) @(posedge CLK);
		i_rst_n <= 1'b1;

		@(posedge CLK);
		cur_test = "reset";
		check_value("o_valid", 32'(1'b0), 32'(o_valid));
		check_value("o_ready", 32'(1'b1), 32'(o_ready));
		tests++;
		$display("Test reset: %0d mismatches", errors);

		run_test("operands", 0);
		run_test("addressing", 1);
		run_test("far_pointer", 2);
		run_test("backpressure", 3);

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timed out after %0d cycles with %0d results still outstanding",
			cycles, exp_q.size());
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
design/decode2_pkg.sv
design/dec_window_if.sv
design/decode2_capture.sv
design/operand_extract.sv
design/addr_decode.sv
design/decode2_assemble.sv
design/decode2_top.sv
verif/tb_decode2.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode2 -f sim.f -o tb_decode2 \
	&& ./obj_dir/tb_decode2 | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -q "Simulation PASSED" sim.log 2>/dev/null && echo "Run result: pass" \
	|| { echo "Run result: fail"; exit 1; }
